// File: verilog/ctrl_defs.svh
// Widths and counts shared by the controller RTL and its testbench
// Kill and halt vectors are indexed with bit 0 as IF and the top bit as WB

`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// Pipeline stages IF, ID, EX, WB
`define CTRL_STAGES 4

// Interrupt id as delivered by the interrupt controller
`define CTRL_IRQ_ID_W 5

// Recorded cause, interrupt flag on top of the cause code
`define CTRL_CAUSE_W 6

`endif

// File: verilog/ctrl_pkg.sv
// Types for the four-stage pipeline controller
// Debug status is one-hot, so each status bit is a state bit

`include "ctrl_defs.svh"

package ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    RESET, BOOT_SET, FUNCTIONAL, SLEEP, DEBUG_TAKEN
  } ctrl_state_e;

  // One-hot debug status
  typedef enum logic [2:0] {
    HAVERESET = 3'b001,
    RUNNING   = 3'b010,
    HALTED    = 3'b100
  } dbg_state_e;

  typedef enum logic [2:0] {
    PC_BOOT, PC_JUMP, PC_BRANCH, PC_EXCEPTION, PC_DRET
  } pc_sel_e;

  // Target selection when pc_sel is PC_EXCEPTION
  typedef enum logic [1:0] {
    IRQ, EXCEPTION, DEBUG_ENTRY, DEBUG_EXCEPTION
  } exc_sel_e;

  typedef enum logic [4:0] {
    INSTR_BUS_FAULT = 5'd1,
    ILLEGAL         = 5'd2,
    BREAKPOINT      = 5'd3,
    ECALL_M         = 5'd11
  } exc_cause_e;

  typedef enum logic [2:0] {
    NONE    = 3'd0,
    EBREAK  = 3'd1,
    HALTREQ = 3'd3
  } dbg_cause_e;

  // Stage whose PC goes to the CSRs
  typedef enum logic [1:0] {
    SAVE_IF, SAVE_ID, SAVE_EX, SAVE_WB
  } save_sel_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Instruction kind in WB, not yet qualified with valid
  typedef struct packed {
    logic valid;
    logic bus_err;
    logic illegal;
    logic ecall;
    logic ebreak;
    logic wfi;
    logic dret;
    logic lsu_en;
  } wb_info_t;

  typedef struct packed {
    logic     id_valid;
    logic     id_jump;
    logic     id_jr_stall;
    logic     ex_valid;
    logic     ex_branch;
    logic     branch_decision;
    logic     if_valid;
    logic     if_ready;
    // Hazard stalls, each one halts ID
    logic     jr_stall;
    logic     load_stall;
    logic     csr_stall;
    logic     wfi_stall;
    wb_info_t wb;
  } pipe_status_t;

  typedef struct packed {
    logic                      exception;
    logic                      wfi;
    logic                      dret;
    logic                      ebreak;
    exc_cause_e                exc_cause;
    logic                      branch_in_ex;
    logic                      jump_in_id;
    logic                      pending_irq;
    logic                      irq_allowed;
    logic [`CTRL_IRQ_ID_W-1:0] irq_id;
    logic                      pending_debug;
    logic                      debug_allowed;
    dbg_cause_e                debug_cause_next;
  } ctrl_events_t;

  typedef struct packed {
    logic                      instr_req;
    logic                      busy;
    logic                      pc_set;
    pc_sel_e                   pc_sel;
    exc_sel_e                  exc_sel;
    logic [`CTRL_STAGES-1:0]   kill;
    logic [`CTRL_STAGES-1:0]   halt;
    logic                      irq_ack;
    logic [`CTRL_IRQ_ID_W-1:0] irq_id;
    logic                      csr_save_cause;
    logic [`CTRL_CAUSE_W-1:0]  csr_cause;
    save_sel_e                 save_sel;
    logic                      save_pc;
    logic                      csr_restore_dret;
    logic                      debug_csr_save;
  } ctrl_out_t;

  typedef struct packed {
    logic       mode;
    logic       havereset;
    logic       running;
    logic       halted;
    dbg_cause_e cause;
  } dbg_status_t;

endpackage

// File: verilog/ctrl_event_decode.sv
// Purely combinational, every event is valid in the cycle of its inputs
// Interrupts are never pending inside debug mode

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_event_decode (
  input  ctrl_pkg::pipe_status_t    pipe_i,
  input  logic                      irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  input  logic                      debug_req_i,
  input  logic                      debug_req_q_i,
  input  logic                      debug_mode_i,
  input  logic                      debug_ebreakm_i,
  output ctrl_pkg::ctrl_events_t    events_o
);

  logic lsu_in_wb;
  logic ebreak_in_wb;
  logic ebreakm_entry;

  // WB kinds only count with a valid instruction behind them
  assign ebreak_in_wb = pipe_i.wb.valid && pipe_i.wb.ebreak;
  assign lsu_in_wb    = pipe_i.wb.valid && pipe_i.wb.lsu_en;

  assign events_o.exception = pipe_i.wb.valid &&
                              (pipe_i.wb.bus_err || pipe_i.wb.illegal ||
                               pipe_i.wb.ecall   || pipe_i.wb.ebreak);
  assign events_o.wfi    = pipe_i.wb.valid && pipe_i.wb.wfi;
  assign events_o.dret   = pipe_i.wb.valid && pipe_i.wb.dret;
  assign events_o.ebreak = ebreak_in_wb;

  // Fixed priority, bus error first and breakpoint last
  assign events_o.exc_cause = pipe_i.wb.bus_err ? ctrl_pkg::INSTR_BUS_FAULT :
                              pipe_i.wb.illegal ? ctrl_pkg::ILLEGAL :
                              pipe_i.wb.ecall   ? ctrl_pkg::ECALL_M :
                                                  ctrl_pkg::BREAKPOINT;

  // Branch needs a resolved taken decision in EX
  assign events_o.branch_in_ex = pipe_i.ex_valid && pipe_i.ex_branch &&
                                 pipe_i.branch_decision;
  // Jump register target not ready yet while jr stalls
  assign events_o.jump_in_id = pipe_i.id_valid && pipe_i.id_jump && !pipe_i.id_jr_stall;

  // Interrupts
  assign events_o.pending_irq = irq_req_i && !debug_mode_i;
  // A load/store in WB must finish on the bus before anything is killed
  assign events_o.irq_allowed = !lsu_in_wb && !debug_mode_i;
  assign events_o.irq_id      = irq_id_i;

  ////////////////////////////////////////////////////////////
  // Debug entry
  ////////////////////////////////////////////////////////////

  // ebreak traps to debug when ebreakm is set
  assign ebreakm_entry = ebreak_in_wb && debug_ebreakm_i && !debug_mode_i;

  // ebreak inside debug mode restarts the debug handler
  assign events_o.pending_debug = ((debug_req_i || debug_req_q_i) && !debug_mode_i) ||
                                  ebreakm_entry ||
                                  (ebreak_in_wb && debug_mode_i);
  assign events_o.debug_allowed = !lsu_in_wb;

  assign events_o.debug_cause_next = ebreakm_entry ? ctrl_pkg::EBREAK : ctrl_pkg::HALTREQ;

endmodule

// File: verilog/ctrl_debug_state.sv
// Debug mode follows the FSM strobes one cycle late
// The halt request is sticky so a short pulse is held until debug mode

`timescale 1ns/1ps

module ctrl_debug_state (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   debug_req_i,
  input  logic                   booted_i,
  input  logic                   take_debug_i,
  input  logic                   enter_debug_i,
  input  logic                   exit_debug_i,
  input  ctrl_pkg::dbg_cause_e   cause_next_i,
  output logic                   debug_req_q_o,
  output ctrl_pkg::dbg_status_t  dbg_o
);

  logic                 mode_q;
  logic                 mode_d;
  ctrl_pkg::dbg_cause_e cause_q;
  ctrl_pkg::dbg_state_e state_q;
  ctrl_pkg::dbg_state_e state_d;

  // Entry wins over exit, they never come together
  assign mode_d = enter_debug_i ? 1'b1 : (exit_debug_i ? 1'b0 : mode_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_req_q_o <= 1'b0;
      mode_q        <= 1'b0;
      cause_q       <= ctrl_pkg::NONE;
      state_q       <= ctrl_pkg::HAVERESET;
    end else begin
      // Sticky request, dropped once the core sits in debug mode
      if (debug_req_i) begin
        debug_req_q_o <= 1'b1;
      end else if (mode_q) begin
        debug_req_q_o <= 1'b0;
      end
      mode_q  <= mode_d;
      state_q <= state_d;
      // Cause is captured on the decision, read back in DEBUG_TAKEN
      if (take_debug_i) begin
        cause_q <= cause_next_i;
      end
    end
  end

  // Status machine, looks at next mode so it moves with mode
  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_pkg::HAVERESET: begin
        if (mode_d) begin
          state_d = ctrl_pkg::HALTED;
        end else if (booted_i) begin
          state_d = ctrl_pkg::RUNNING;
        end
      end
      ctrl_pkg::RUNNING: begin
        if (mode_d) begin
          state_d = ctrl_pkg::HALTED;
        end
      end
      ctrl_pkg::HALTED: begin
        if (!mode_d) begin
          state_d = ctrl_pkg::RUNNING;
        end
      end
      default: state_d = ctrl_pkg::HAVERESET;
    endcase
  end

  assign dbg_o.mode      = mode_q;
  assign dbg_o.havereset = state_q[0];
  assign dbg_o.running   = state_q[1];
  assign dbg_o.halted    = state_q[2];
  assign dbg_o.cause     = cause_q;

endmodule

// File: verilog/ctrl_main_fsm.sv
// All outputs are combinational from state and the same-cycle events
// Only one redirect per issued instruction, held by the taken-once flag

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_main_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_enable_i,
  input  ctrl_pkg::pipe_status_t  pipe_i,
  input  ctrl_pkg::ctrl_events_t  events_i,
  input  logic                    irq_wu_i,
  input  ctrl_pkg::dbg_status_t   dbg_i,
  output ctrl_pkg::ctrl_out_t     ctrl_o,
  output logic                    booted_o,
  output logic                    take_debug_o,
  output logic                    enter_debug_o,
  output logic                    exit_debug_o
);

  // IF, ID and EX, WB left alone
  localparam logic [`CTRL_STAGES-1:0] KILL_FRONT = {1'b0, {(`CTRL_STAGES-1){1'b1}}};

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;
  logic                  taken_q;
  logic                  taken_d;
  ctrl_pkg::save_sel_e   oldest_sel;
  logic                  ebreak_in_dm;

  // Oldest valid stage, IF always holds a valid next PC
  always_comb begin
    if (pipe_i.wb.valid) begin
      oldest_sel = ctrl_pkg::SAVE_WB;
    end else if (pipe_i.ex_valid) begin
      oldest_sel = ctrl_pkg::SAVE_EX;
    end else if (pipe_i.id_valid) begin
      oldest_sel = ctrl_pkg::SAVE_ID;
    end else begin
      oldest_sel = ctrl_pkg::SAVE_IF;
    end
  end

  // Re-entry of the debug handler, no CSR update and WB kept
  assign ebreak_in_dm = events_i.ebreak && dbg_i.mode;

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d                 = state_q;
    taken_d                 = taken_q;
    booted_o                = 1'b0;
    take_debug_o            = 1'b0;
    enter_debug_o           = 1'b0;
    exit_debug_o            = 1'b0;
    ctrl_o.instr_req        = 1'b1;
    ctrl_o.busy             = 1'b1;
    ctrl_o.pc_set           = 1'b0;
    ctrl_o.pc_sel           = ctrl_pkg::PC_BOOT;
    ctrl_o.exc_sel          = ctrl_pkg::IRQ;
    ctrl_o.kill             = '0;
    ctrl_o.halt             = '0;
    ctrl_o.irq_ack          = 1'b0;
    ctrl_o.irq_id           = '0;
    ctrl_o.csr_save_cause   = 1'b0;
    ctrl_o.csr_cause        = '0;
    ctrl_o.save_sel         = ctrl_pkg::SAVE_IF;
    ctrl_o.save_pc          = 1'b0;
    ctrl_o.csr_restore_dret = 1'b0;
    ctrl_o.debug_csr_save   = 1'b0;

    // ID held on hazards, and on events that wait for WB to drain
    ctrl_o.halt[1] = pipe_i.jr_stall || pipe_i.load_stall ||
                     pipe_i.csr_stall || pipe_i.wfi_stall ||
                     (events_i.pending_irq && !events_i.irq_allowed) ||
                     (events_i.pending_debug && !events_i.debug_allowed);

    case (state_q)
      ctrl_pkg::RESET: begin
        ctrl_o.instr_req = 1'b0;
        if (fetch_enable_i) begin
          booted_o = 1'b1;
          state_d  = ctrl_pkg::BOOT_SET;
        end
      end
      ctrl_pkg::BOOT_SET: begin
        ctrl_o.pc_set = 1'b1;
        ctrl_o.pc_sel = ctrl_pkg::PC_BOOT;
        state_d       = ctrl_pkg::FUNCTIONAL;
      end
      ctrl_pkg::FUNCTIONAL: begin
        if (events_i.pending_debug && events_i.debug_allowed) begin
          // Freeze everything, the entry itself is done next cycle
          ctrl_o.halt  = '1;
          take_debug_o = 1'b1;
          state_d      = ctrl_pkg::DEBUG_TAKEN;
        end else if (events_i.pending_irq && events_i.irq_allowed) begin
          ctrl_o.kill           = '1;
          ctrl_o.pc_set         = 1'b1;
          ctrl_o.pc_sel         = ctrl_pkg::PC_EXCEPTION;
          ctrl_o.exc_sel        = ctrl_pkg::IRQ;
          ctrl_o.irq_ack        = 1'b1;
          ctrl_o.irq_id         = events_i.irq_id;
          ctrl_o.csr_save_cause = 1'b1;
          ctrl_o.csr_cause      = {1'b1, events_i.irq_id};
          ctrl_o.save_pc        = 1'b1;
          ctrl_o.save_sel       = oldest_sel;
        end else if (events_i.exception) begin
          // Write enables are already suppressed in WB
          ctrl_o.kill           = KILL_FRONT;
          ctrl_o.pc_set         = 1'b1;
          ctrl_o.pc_sel         = ctrl_pkg::PC_EXCEPTION;
          ctrl_o.exc_sel        = dbg_i.mode ? ctrl_pkg::DEBUG_EXCEPTION : ctrl_pkg::EXCEPTION;
          ctrl_o.csr_save_cause = !dbg_i.mode;
          ctrl_o.csr_cause      = {1'b0, events_i.exc_cause};
          ctrl_o.save_pc        = 1'b1;
          ctrl_o.save_sel       = ctrl_pkg::SAVE_WB;
        end else if (events_i.wfi) begin
          // EX and WB keep moving so a bubble reaches WB
          ctrl_o.halt[1:0] = 2'b11;
          ctrl_o.instr_req = 1'b0;
          state_d          = ctrl_pkg::SLEEP;
        end else if (events_i.dret) begin
          ctrl_o.kill             = KILL_FRONT;
          ctrl_o.pc_set           = 1'b1;
          ctrl_o.pc_sel           = ctrl_pkg::PC_DRET;
          ctrl_o.csr_restore_dret = 1'b1;
          exit_debug_o            = 1'b1;
        end else if (events_i.branch_in_ex && !taken_q) begin
          ctrl_o.kill[1:0] = 2'b11;
          ctrl_o.pc_set    = 1'b1;
          ctrl_o.pc_sel    = ctrl_pkg::PC_BRANCH;
          taken_d          = 1'b1;
        end else if (events_i.jump_in_id && !taken_q) begin
          ctrl_o.kill[0] = 1'b1;
          ctrl_o.pc_set  = 1'b1;
          ctrl_o.pc_sel  = ctrl_pkg::PC_JUMP;
          taken_d        = 1'b1;
        end
      end
      ctrl_pkg::SLEEP: begin
        ctrl_o.busy      = 1'b0;
        ctrl_o.instr_req = 1'b0;
        // Halting WB holds the whole pipe
        ctrl_o.halt[`CTRL_STAGES-1] = 1'b1;
        if (irq_wu_i || events_i.pending_debug || dbg_i.mode) begin
          ctrl_o.busy = 1'b1;
          state_d     = ctrl_pkg::FUNCTIONAL;
        end
      end
      ctrl_pkg::DEBUG_TAKEN: begin
        ctrl_o.pc_set         = 1'b1;
        ctrl_o.pc_sel         = ctrl_pkg::PC_EXCEPTION;
        ctrl_o.exc_sel        = ctrl_pkg::DEBUG_ENTRY;
        ctrl_o.debug_csr_save = 1'b1;
        ctrl_o.csr_save_cause = !ebreak_in_dm;
        ctrl_o.save_pc        = 1'b1;
        ctrl_o.save_sel       = oldest_sel;
        ctrl_o.kill           = KILL_FRONT;
        // The ebreak that caused entry is reported as retired
        ctrl_o.kill[`CTRL_STAGES-1] = !((dbg_i.cause == ctrl_pkg::EBREAK) || ebreak_in_dm);
        enter_debug_o = 1'b1;
        state_d       = ctrl_pkg::FUNCTIONAL;
      end
      default: begin
        ctrl_o.instr_req = 1'b0;
        state_d          = ctrl_pkg::RESET;
      end
    endcase

    // New instruction issued from IF, redirects allowed again
    if (taken_q && pipe_i.if_valid && pipe_i.if_ready) begin
      taken_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ctrl_pkg::RESET;
      taken_q <= 1'b0;
    end else begin
      state_q <= state_d;
      taken_q <= taken_d;
    end
  end

endmodule

// File: verilog/ctrl_top.sv
// Pipeline controller top, event decode, debug state and main FSM
// Debug mode reaches the decode through dbg_o.mode

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_enable_i,
  input  ctrl_pkg::pipe_status_t    pipe_i,
  input  logic                      irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  input  logic                      irq_wu_i,
  input  logic                      debug_req_i,
  input  logic                      debug_ebreakm_i,
  output ctrl_pkg::ctrl_out_t       ctrl_o,
  output ctrl_pkg::dbg_status_t     dbg_o
);

  ctrl_pkg::ctrl_events_t events;
  logic                   debug_req_q;
  logic                   booted;
  logic                   take_debug;
  logic                   enter_debug;
  logic                   exit_debug;

  ctrl_event_decode u_decode (
    .pipe_i          (pipe_i),
    .irq_req_i       (irq_req_i),
    .irq_id_i        (irq_id_i),
    .debug_req_i     (debug_req_i),
    .debug_req_q_i   (debug_req_q),
    .debug_mode_i    (dbg_o.mode),
    .debug_ebreakm_i (debug_ebreakm_i),
    .events_o        (events)
  );

  ctrl_debug_state u_debug (
    .clk           (clk),
    .rst_n         (rst_n),
    .debug_req_i   (debug_req_i),
    .booted_i      (booted),
    .take_debug_i  (take_debug),
    .enter_debug_i (enter_debug),
    .exit_debug_i  (exit_debug),
    .cause_next_i  (events.debug_cause_next),
    .debug_req_q_o (debug_req_q),
    .dbg_o         (dbg_o)
  );

  ctrl_main_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .pipe_i         (pipe_i),
    .events_i       (events),
    .irq_wu_i       (irq_wu_i),
    .dbg_i          (dbg_o),
    .ctrl_o         (ctrl_o),
    .booted_o       (booted),
    .take_debug_o   (take_debug),
    .enter_debug_o  (enter_debug),
    .exit_debug_o   (exit_debug)
  );

endmodule

// File: verification/ctrl_props.sv
// Bound into ctrl_top, port-level rules checked on every clock out of reset
// The first cycle after reset release is tracked locally

`timescale 1ns/1ps

module ctrl_props (
  input logic                  clk,
  input logic                  rst_n,
  input ctrl_pkg::ctrl_out_t   ctrl_i,
  input ctrl_pkg::dbg_status_t dbg_i
);

  logic first_q;

  // High only in the first cycle after reset is released
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= 1'b1;
    end else begin
      first_q <= 1'b0;
    end
  end

  // No fetch while the core reports idle
  req_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !ctrl_i.busy |-> !ctrl_i.instr_req)
    else $error("instr_req is high while busy is low");

  // Acknowledged interrupt always redirects to the trap vector
  ack_redirects: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.irq_ack |-> (ctrl_i.pc_set && ctrl_i.pc_sel == ctrl_pkg::PC_EXCEPTION))
    else $error("irq_ack without pc_set to the exception vector");

  dbg_status_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(dbg_i.running && dbg_i.halted))
    else $error("debug status is running and halted at once");

  no_early_pc_set: assert property (@(posedge clk) disable iff (!rst_n)
    first_q |-> !ctrl_i.pc_set)
    else $error("pc_set in the first cycle after reset");

endmodule

bind ctrl_top ctrl_props u_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .ctrl_i (ctrl_o),
  .dbg_i  (dbg_o)
);

// File: verification/ctrl_tb.sv
// One table row per clock with inputs driven on the falling edge
// Outputs are checked 2 ns after the drive and well before the next rising edge

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_tb;

  localparam int RESET_CYCLES = 4;

  typedef struct packed {
    logic                      fetch_enable;
    ctrl_pkg::pipe_status_t    pipe;
    logic                      irq_req;
    logic [`CTRL_IRQ_ID_W-1:0] irq_id;
    logic                      irq_wu;
    logic                      debug_req;
    logic                      ebreakm;
  } stim_t;

  // Stimulus, expected outputs and flags for the fields checked only sometimes
  typedef struct packed {
    stim_t                 stim;
    ctrl_pkg::ctrl_out_t   ctrl;
    ctrl_pkg::dbg_status_t dbg;
    logic                  chk_save;
    logic                  chk_dbg_cause;
  } row_t;

  logic                      clk;
  logic                      rst_n;
  logic                      fetch_enable;
  ctrl_pkg::pipe_status_t    pipe;
  logic                      irq_req;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id;
  logic                      irq_wu;
  logic                      debug_req;
  logic                      ebreakm;
  ctrl_pkg::ctrl_out_t       ctrl_o;
  ctrl_pkg::dbg_status_t     dbg_o;

  string       names[$];
  row_t        rows[$];
  logic [31:0] lcg_state = 32'd89;
  int          cycles = 0;
  int          cycle_limit = 0;

  ctrl_top u_ctrl_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_enable_i  (fetch_enable),
    .pipe_i          (pipe),
    .irq_req_i       (irq_req),
    .irq_id_i        (irq_id),
    .irq_wu_i        (irq_wu),
    .debug_req_i     (debug_req),
    .debug_ebreakm_i (ebreakm),
    .ctrl_o          (ctrl_o),
    .dbg_o           (dbg_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Fetch enabled, idle pipe, quiet FUNCTIONAL outputs, debug running
  function automatic row_t base_row();
    row_t r;
    r = '0;
    r.stim.fetch_enable = 1'b1;
    r.ctrl.instr_req    = 1'b1;
    r.ctrl.busy         = 1'b1;
    r.dbg.running       = 1'b1;
    return r;
  endfunction

  task automatic add_row(input string n, input row_t r);
    names.push_back(n);
    rows.push_back(r);
  endtask

  task automatic fail_and_stop();
    $display("Done: errors found");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string n, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s: %s expected 0x%0h actual 0x%0h", n, field, exp, act);
    fail_and_stop();
  endtask

  task automatic expect_eq(input string n, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else report_mismatch(n, field, exp, act);
  endtask

  task automatic drive_row(input row_t r);
    fetch_enable = r.stim.fetch_enable;
    pipe         = r.stim.pipe;
    irq_req      = r.stim.irq_req;
    irq_id       = r.stim.irq_id;
    irq_wu       = r.stim.irq_wu;
    debug_req    = r.stim.debug_req;
    ebreakm      = r.stim.ebreakm;
  endtask

  task automatic check_row(input string n, input row_t r);
    expect_eq(n, "instr_req", 32'(r.ctrl.instr_req), 32'(ctrl_o.instr_req));
    expect_eq(n, "busy", 32'(r.ctrl.busy), 32'(ctrl_o.busy));
    expect_eq(n, "pc_set", 32'(r.ctrl.pc_set), 32'(ctrl_o.pc_set));
    expect_eq(n, "kill", 32'(r.ctrl.kill), 32'(ctrl_o.kill));
    expect_eq(n, "halt", 32'(r.ctrl.halt), 32'(ctrl_o.halt));
    expect_eq(n, "irq_ack", 32'(r.ctrl.irq_ack), 32'(ctrl_o.irq_ack));
    expect_eq(n, "csr_save_cause", 32'(r.ctrl.csr_save_cause), 32'(ctrl_o.csr_save_cause));
    expect_eq(n, "save_pc", 32'(r.ctrl.save_pc), 32'(ctrl_o.save_pc));
    expect_eq(n, "csr_restore_dret", 32'(r.ctrl.csr_restore_dret),
              32'(ctrl_o.csr_restore_dret));
    expect_eq(n, "debug_csr_save", 32'(r.ctrl.debug_csr_save), 32'(ctrl_o.debug_csr_save));
    expect_eq(n, "dbg_mode", 32'(r.dbg.mode), 32'(dbg_o.mode));
    expect_eq(n, "havereset", 32'(r.dbg.havereset), 32'(dbg_o.havereset));
    expect_eq(n, "running", 32'(r.dbg.running), 32'(dbg_o.running));
    expect_eq(n, "halted", 32'(r.dbg.halted), 32'(dbg_o.halted));
    // Selects only mean something while their strobe is up
    if (r.ctrl.pc_set) begin
      expect_eq(n, "pc_sel", 32'(r.ctrl.pc_sel), 32'(ctrl_o.pc_sel));
      if (r.ctrl.pc_sel == ctrl_pkg::PC_EXCEPTION) begin
        expect_eq(n, "exc_sel", 32'(r.ctrl.exc_sel), 32'(ctrl_o.exc_sel));
      end
    end
    if (r.ctrl.irq_ack) begin
      expect_eq(n, "irq_id", 32'(r.ctrl.irq_id), 32'(ctrl_o.irq_id));
    end
    if (r.ctrl.csr_save_cause && !r.ctrl.debug_csr_save) begin
      expect_eq(n, "csr_cause", 32'(r.ctrl.csr_cause), 32'(ctrl_o.csr_cause));
    end
    if (r.chk_save) begin
      expect_eq(n, "save_sel", 32'(r.ctrl.save_sel), 32'(ctrl_o.save_sel));
    end
    if (r.chk_dbg_cause) begin
      expect_eq(n, "dbg_cause", 32'(r.dbg.cause), 32'(dbg_o.cause));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Table with one entry per cycle in order
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    row_t                      r;
    logic [`CTRL_IRQ_ID_W-1:0] id;
    // Boot
    r = base_row();
    r.stim.fetch_enable = 1'b0;
    r.ctrl.instr_req    = 1'b0;
    r.dbg.running       = 1'b0;
    r.dbg.havereset     = 1'b1;
    add_row("reset_idle", r);
    r.stim.fetch_enable = 1'b1;
    add_row("boot_enable", r);
    r = base_row();
    r.ctrl.pc_set = 1'b1;
    r.ctrl.pc_sel = ctrl_pkg::PC_BOOT;
    add_row("boot_set", r);
    add_row("functional_idle", base_row());
    // Interrupt with EX as the oldest valid stage
    lcg_state = lcg_next(lcg_state);
    id = lcg_state[20:16];
    r = base_row();
    r.stim.irq_req        = 1'b1;
    r.stim.irq_id         = id;
    r.stim.pipe.ex_valid  = 1'b1;
    r.stim.pipe.id_valid  = 1'b1;
    r.ctrl.pc_set         = 1'b1;
    r.ctrl.pc_sel         = ctrl_pkg::PC_EXCEPTION;
    r.ctrl.exc_sel        = ctrl_pkg::IRQ;
    r.ctrl.kill           = 4'b1111;
    r.ctrl.irq_ack        = 1'b1;
    r.ctrl.irq_id         = id;
    r.ctrl.csr_save_cause = 1'b1;
    r.ctrl.csr_cause      = {1'b1, id};
    r.ctrl.save_pc        = 1'b1;
    r.ctrl.save_sel       = ctrl_pkg::SAVE_EX;
    r.chk_save            = 1'b1;
    add_row("irq_taken", r);
    // Load/store in WB holds the interrupt back
    lcg_state = lcg_next(lcg_state);
    id = lcg_state[20:16];
    r = base_row();
    r.stim.irq_req        = 1'b1;
    r.stim.irq_id         = id;
    r.stim.pipe.wb.valid  = 1'b1;
    r.stim.pipe.wb.lsu_en = 1'b1;
    r.ctrl.halt           = 4'b0010;
    add_row("irq_blocked_lsu", r);
    // WB drained so WB is now the oldest stage
    r.stim.pipe.wb.lsu_en = 1'b0;
    r.stim.pipe.ex_valid  = 1'b1;
    r.ctrl.halt           = 4'b0000;
    r.ctrl.pc_set         = 1'b1;
    r.ctrl.pc_sel         = ctrl_pkg::PC_EXCEPTION;
    r.ctrl.exc_sel        = ctrl_pkg::IRQ;
    r.ctrl.kill           = 4'b1111;
    r.ctrl.irq_ack        = 1'b1;
    r.ctrl.irq_id         = id;
    r.ctrl.csr_save_cause = 1'b1;
    r.ctrl.csr_cause      = {1'b1, id};
    r.ctrl.save_pc        = 1'b1;
    r.ctrl.save_sel       = ctrl_pkg::SAVE_WB;
    r.chk_save            = 1'b1;
    add_row("irq_wb_oldest", r);
    // Illegal beats ecall and bus error beats both
    r = base_row();
    r.stim.pipe.wb.valid   = 1'b1;
    r.stim.pipe.wb.illegal = 1'b1;
    r.stim.pipe.wb.ecall   = 1'b1;
    r.ctrl.pc_set          = 1'b1;
    r.ctrl.pc_sel          = ctrl_pkg::PC_EXCEPTION;
    r.ctrl.exc_sel         = ctrl_pkg::EXCEPTION;
    r.ctrl.kill            = 4'b0111;
    r.ctrl.csr_save_cause  = 1'b1;
    r.ctrl.csr_cause       = {1'b0, ctrl_pkg::ILLEGAL};
    r.ctrl.save_pc         = 1'b1;
    r.ctrl.save_sel        = ctrl_pkg::SAVE_WB;
    r.chk_save             = 1'b1;
    add_row("exc_illegal_ecall", r);
    r.stim.pipe.wb.bus_err = 1'b1;
    r.ctrl.csr_cause       = {1'b0, ctrl_pkg::INSTR_BUS_FAULT};
    add_row("exc_bus_err", r);
    // Branch redirects once until IF issues
    r = base_row();
    r.stim.pipe.ex_valid        = 1'b1;
    r.stim.pipe.ex_branch       = 1'b1;
    r.stim.pipe.branch_decision = 1'b1;
    r.ctrl.pc_set               = 1'b1;
    r.ctrl.pc_sel               = ctrl_pkg::PC_BRANCH;
    r.ctrl.kill                 = 4'b0011;
    add_row("branch_taken", r);
    r.stim.pipe.if_valid = 1'b1;
    r.ctrl.pc_set        = 1'b0;
    r.ctrl.kill          = 4'b0000;
    add_row("branch_repeat", r);
    r = base_row();
    r.stim.pipe.if_valid = 1'b1;
    r.stim.pipe.if_ready = 1'b1;
    add_row("if_issue", r);
    r = base_row();
    r.stim.pipe.id_valid = 1'b1;
    r.stim.pipe.id_jump  = 1'b1;
    r.ctrl.pc_set        = 1'b1;
    r.ctrl.pc_sel        = ctrl_pkg::PC_JUMP;
    r.ctrl.kill          = 4'b0001;
    add_row("jump_in_id", r);
    r = base_row();
    r.stim.pipe.if_valid = 1'b1;
    r.stim.pipe.if_ready = 1'b1;
    add_row("if_issue_after_jump", r);
    // WFI, sleep and wake-up
    r = base_row();
    r.stim.pipe.wb.valid = 1'b1;
    r.stim.pipe.wb.wfi   = 1'b1;
    r.ctrl.halt          = 4'b0011;
    r.ctrl.instr_req     = 1'b0;
    add_row("wfi_in_wb", r);
    r = base_row();
    r.ctrl.busy      = 1'b0;
    r.ctrl.instr_req = 1'b0;
    r.ctrl.halt      = 4'b1000;
    add_row("sleep", r);
    add_row("sleep_hold", r);
    r.stim.irq_wu = 1'b1;
    r.ctrl.busy   = 1'b1;
    add_row("wake_irq_wu", r);
    add_row("after_wake", base_row());
    // Halt request while WB holds a load/store is kept by the sticky flag
    r = base_row();
    r.stim.debug_req      = 1'b1;
    r.stim.pipe.wb.valid  = 1'b1;
    r.stim.pipe.wb.lsu_en = 1'b1;
    r.ctrl.halt           = 4'b0010;
    add_row("debug_req_pulse", r);
    r = base_row();
    r.ctrl.halt = 4'b1111;
    add_row("debug_take", r);
    r = base_row();
    r.ctrl.pc_set         = 1'b1;
    r.ctrl.pc_sel         = ctrl_pkg::PC_EXCEPTION;
    r.ctrl.exc_sel        = ctrl_pkg::DEBUG_ENTRY;
    r.ctrl.kill           = 4'b1111;
    r.ctrl.csr_save_cause = 1'b1;
    r.ctrl.save_pc        = 1'b1;
    r.ctrl.debug_csr_save = 1'b1;
    r.dbg.cause           = ctrl_pkg::HALTREQ;
    r.chk_dbg_cause       = 1'b1;
    add_row("debug_entry", r);
    r = base_row();
    r.dbg.mode      = 1'b1;
    r.dbg.running   = 1'b0;
    r.dbg.halted    = 1'b1;
    r.dbg.cause     = ctrl_pkg::HALTREQ;
    r.chk_dbg_cause = 1'b1;
    add_row("debug_halted", r);
    // dret leaves debug mode one cycle later
    r.stim.pipe.wb.valid    = 1'b1;
    r.stim.pipe.wb.dret     = 1'b1;
    r.ctrl.pc_set           = 1'b1;
    r.ctrl.pc_sel           = ctrl_pkg::PC_DRET;
    r.ctrl.kill             = 4'b0111;
    r.ctrl.csr_restore_dret = 1'b1;
    add_row("dret", r);
    add_row("debug_resumed", base_row());
    // ebreak with ebreakm leaves WB alive through the entry
    r = base_row();
    r.stim.ebreakm        = 1'b1;
    r.stim.pipe.wb.valid  = 1'b1;
    r.stim.pipe.wb.ebreak = 1'b1;
    r.ctrl.halt           = 4'b1111;
    add_row("ebreakm_take", r);
    r.ctrl.halt           = 4'b0000;
    r.ctrl.pc_set         = 1'b1;
    r.ctrl.pc_sel         = ctrl_pkg::PC_EXCEPTION;
    r.ctrl.exc_sel        = ctrl_pkg::DEBUG_ENTRY;
    r.ctrl.kill           = 4'b0111;
    r.ctrl.csr_save_cause = 1'b1;
    r.ctrl.save_pc        = 1'b1;
    r.ctrl.debug_csr_save = 1'b1;
    r.dbg.cause           = ctrl_pkg::EBREAK;
    r.chk_dbg_cause       = 1'b1;
    add_row("ebreakm_entry", r);
    r = base_row();
    r.dbg.mode      = 1'b1;
    r.dbg.running   = 1'b0;
    r.dbg.halted    = 1'b1;
    r.dbg.cause     = ctrl_pkg::EBREAK;
    r.chk_dbg_cause = 1'b1;
    add_row("ebreak_halted", r);
  endtask

  ////////////////////////////////////////////////////////////
  // Run
  ////////////////////////////////////////////////////////////

  // Timeout counts every clock including reset
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the table did not complete", cycles);
      fail_and_stop();
    end
  end

  initial begin
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    pipe         = '0;
    irq_req      = 1'b0;
    irq_id       = '0;
    irq_wu       = 1'b0;
    debug_req    = 1'b0;
    ebreakm      = 1'b0;
    build_table();
    cycle_limit = rows.size() + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge clk);
      drive_row(rows[i]);
      #2;
      check_row(names[i], rows[i]);
    end
    @(negedge clk);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: ctrl_top.f
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/ctrl_event_decode.sv
verilog/ctrl_debug_state.sv
verilog/ctrl_main_fsm.sv
verilog/ctrl_top.sv
verification/ctrl_props.sv
verification/ctrl_tb.sv

// File: Makefile
# Verilator build and run of the pipeline controller testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= ctrl_tb
FILELIST  ?= ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
